//--- files.f
+incdir+tb
design/lsq_pkg.sv
design/lsq_entry.sv
design/lsq_mem_credit.sv
design/lsq_queue.sv
design/lsq_top.sv
tb/lsq_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := lsq_tb
FILELIST := files.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	-./$(BUILD)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb/lsq_tb_table.svh
// Operation table with stimulus and expected request fields, and the LFSR used for delays
`ifndef LSQ_TB_TABLE_SVH
`define LSQ_TB_TABLE_SVH

localparam int ROWS = 32;

// Columns: read flag, tag, address, value, writeback delay in cycles, dispatch port
logic              t_read  [ROWS];
logic [TAG_W-1:0]  t_tag   [ROWS];
logic [DATA_W-1:0] t_addr  [ROWS];
logic [DATA_W-1:0] t_value [ROWS];
int                t_delay [ROWS];
int                t_port  [ROWS];

logic [15:0] lfsr_state = 16'd29;

task automatic set_row(int r, logic rd, int tg, logic [DATA_W-1:0] ad,
                       logic [DATA_W-1:0] vl, int dl, int pt);
  t_read[r]  = rd;
  t_tag[r]   = TAG_W'(tg);
  t_addr[r]  = ad;
  t_value[r] = vl;
  t_delay[r] = dl;
  t_port[r]  = pt;
endtask

task automatic load_table();
  int i;
  set_row(0,  1'b1, 0,  64'h0000_4000_0000_0000, 64'h1111_0000_0000_0000, 2, 1);
  set_row(1,  1'b1, 1,  64'h0000_4000_0000_0010, 64'h2222_0000_0000_0001, 0, 2);
  set_row(2,  1'b0, 2,  64'h0000_4000_0000_0020, 64'hCAFE_F00D_0000_0002, 5, 1);
  set_row(3,  1'b1, 3,  64'h0000_4000_0000_0030, 64'h3333_0000_0000_0003, 1, 2);
  set_row(4,  1'b1, 4,  64'h0000_4000_0000_0040, 64'h4444_0000_0000_0004, 6, 2);
  set_row(5,  1'b0, 5,  64'h0000_4000_0000_0050, 64'hDEAD_BEEF_0000_0005, 0, 1);
  set_row(6,  1'b1, 6,  64'h0000_4000_0000_0060, 64'h6666_0000_0000_0006, 3, 1);
  set_row(7,  1'b1, 7,  64'h0000_4000_0000_0070, 64'h7777_0000_0000_0007, 9, 1);
  set_row(8,  1'b1, 8,  64'h0000_4000_0000_0080, 64'h8888_0000_0000_0008, 1, 2);
  set_row(9,  1'b0, 9,  64'h0000_4000_0000_0090, 64'hA5A5_5A5A_0000_0009, 2, 1);
  set_row(10, 1'b0, 10, 64'h0000_4000_0000_00A0, 64'h5A5A_A5A5_0000_000A, 2, 2);
  set_row(11, 1'b1, 11, 64'h0000_4000_0000_00B0, 64'hBBBB_0000_0000_000B, 4, 2);
  set_row(12, 1'b1, 12, 64'h0000_4000_0000_00C0, 64'hCCCC_0000_0000_000C, 0, 1);
  set_row(13, 1'b1, 13, 64'h0000_4000_0000_00D0, 64'hDDDD_0000_0000_000D, 0, 2);
  set_row(14, 1'b1, 14, 64'h0000_4000_0000_00E0, 64'hEEEE_0000_0000_000E, 1, 2);
  set_row(15, 1'b0, 15, 64'h0000_4000_0000_00F0, 64'hFFFF_0123_0000_000F, 7, 1);
  // Burst behind a slow store, enough to fill every slot
  for (i = 0; i < 16; i++) begin
    set_row(16 + i, i != 0, 16 + i, 64'h8000_0000_0000_0000 + 64'(i * 64),
            64'hB0B0_0000_0000_0000 | 64'(i), (i == 0) ? 60 : i % 4, 1 + i % 2);
  end
endtask

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic int draw_bits(int n);
  int   result;
  int   k;
  logic fb;
  result = 0;
  for (k = 0; k < n; k++) begin
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    result = (result << 1) | int'(fb);
  end
  return result;
endfunction

`endif

//--- tb/lsq_tb.sv
// Load/store queue testbench with clock, drivers, ROB and memory models, checker and watchdog
module lsq_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import lsq_pkg::*;

  logic                  clock;
  logic                  reset;
  logic                  disp_valid_1;
  logic                  disp_valid_2;
  logic                  disp_read_1;
  logic                  disp_read_2;
  logic [TAG_W-1:0]      disp_tag_1;
  logic [TAG_W-1:0]      disp_tag_2;
  logic [TAG_W-1:0]      ex_tag_1;
  logic [TAG_W-1:0]      ex_tag_2;
  logic [TAG_W-1:0]      mem_req_tag;
  logic                  ex_valid_1;
  logic                  ex_valid_2;
  logic [DATA_W-1:0]     ex_addr_1;
  logic [DATA_W-1:0]     ex_addr_2;
  logic [DATA_W-1:0]     ex_value_1;
  logic [DATA_W-1:0]     ex_value_2;
  logic [DATA_W-1:0]     mem_req_addr;
  logic [DATA_W-1:0]     mem_req_value;
  logic [ROB_HEAD_W-1:0] rob_head_1;
  logic [ROB_HEAD_W-1:0] rob_head_2;
  logic                  mem_credit_return;
  logic                  mem_req_valid;
  logic                  mem_req_read;
  logic                  disp_credit_return;

  `include "lsq_tb_table.svh"

  localparam int HOLD_ROW    = 18;
  localparam int HOLD_CYCLES = 20;
  localparam int ROB_WAIT    = 2;

  int cycle;
  int next_row;
  int next_issue;
  int disp_credits;
  int min_credits;
  int outstanding;
  int max_out;
  int requests;
  int credit_pulses;
  int hold_until;
  int value_errors;
  int protocol_errors;
  int rob_row;
  int rob_wait;
  int wb_cycle [ROWS];
  int wb_row [$];
  int wb_due [$];
  int ret_due [$];

  lsq_top dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic show_mismatch(string name, logic [DATA_W-1:0] expected,
                               logic [DATA_W-1:0] actual);
    value_errors++;
    $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
  endtask

  task automatic report_problem(string what);
    protocol_errors++;
    $display("[ERROR] t=%0t %s", $time, what);
  endtask

  // Put the next table row on one dispatch port and schedule its writeback
  task automatic start_row(int port);
    int r;
    r = next_row;
    if (port == 1) begin
      disp_valid_1 <= 1'b1;
      disp_tag_1   <= t_tag[r];
      disp_read_1  <= t_read[r];
    end else begin
      disp_valid_2 <= 1'b1;
      disp_tag_2   <= t_tag[r];
      disp_read_2  <= t_read[r];
    end
    wb_row.push_back(r);
    wb_due.push_back(cycle + t_delay[r]);
    disp_credits--;
    next_row++;
  endtask

  //////////////////////////////////////////////////////////////
  // Rising edge drivers
  //////////////////////////////////////////////////////////////

  task automatic drive_cycle();
    int i;
    int r;
    int n_wb;
    int store_row;
    cycle++;
    disp_valid_1      <= 1'b0;
    disp_valid_2      <= 1'b0;
    ex_valid_1        <= 1'b0;
    ex_valid_2        <= 1'b0;
    mem_credit_return <= 1'b0;
    // ROB head words track the oldest queued store and start out busy
    store_row = -1;
    for (i = next_row - 1; i >= next_issue; i--) begin
      if (!t_read[i]) store_row = i;
    end
    if (store_row != rob_row) begin
      rob_row  = store_row;
      rob_wait = ROB_WAIT;
    end
    // Odd store rows commit through the second head word
    if (store_row < 0) begin
      rob_head_1 <= {3'b111, TAG_W'(0)};
      rob_head_2 <= {3'b111, TAG_W'(0)};
    end else if (store_row % 2 == 0) begin
      rob_head_1 <= {(rob_wait > 0) ? 3'b010 : 3'b000, t_tag[store_row]};
      rob_head_2 <= {3'b100, t_tag[store_row]};
    end else begin
      rob_head_1 <= {3'b100, t_tag[store_row]};
      rob_head_2 <= {(rob_wait > 0) ? 3'b010 : 3'b000, t_tag[store_row]};
    end
    if (rob_wait > 0) rob_wait--;
    // Pair a port 1 row with a following port 2 row
    if (next_row < ROWS && disp_credits > 0) begin
      if (t_port[next_row] == 2) begin
        start_row(2);
      end else begin
        start_row(1);
        if (next_row < ROWS && disp_credits > 0 && t_port[next_row] == 2) start_row(2);
      end
    end
    if (disp_credits < min_credits) min_credits = disp_credits;
    // Up to two due writebacks with the oldest scheduled first
    i = 0;
    n_wb = 0;
    while (i < wb_row.size() && n_wb < 2) begin
      if (wb_due[i] <= cycle) begin
        r = wb_row[i];
        if (n_wb == 0) begin
          ex_valid_1 <= 1'b1;
          ex_tag_1   <= t_tag[r];
          ex_addr_1  <= t_addr[r];
          ex_value_1 <= t_value[r];
        end else begin
          ex_valid_2 <= 1'b1;
          ex_tag_2   <= t_tag[r];
          ex_addr_2  <= t_addr[r];
          ex_value_2 <= t_value[r];
        end
        wb_cycle[r] = cycle;
        wb_row.delete(i);
        wb_due.delete(i);
        n_wb++;
      end else begin
        i++;
      end
    end
    // Memory hands back one credit per cycle and none during the hold window
    if (cycle >= hold_until && ret_due.size() > 0 && ret_due[0] <= cycle) begin
      mem_credit_return <= 1'b1;
      void'(ret_due.pop_front());
      outstanding--;
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Falling edge checks
  //////////////////////////////////////////////////////////////

  task automatic observe_cycle();
    int r;
    if (disp_credit_return !== mem_req_valid) begin
      report_problem("dispatch credit return does not follow the memory request");
    end
    if (disp_credit_return === 1'b1) begin
      disp_credits++;
      credit_pulses++;
    end
    if (disp_credits > LSQ_ENTRIES) report_problem("more dispatch credits than queue slots");
    if (mem_req_valid === 1'b1) begin
      r = next_issue;
      if (r >= ROWS) begin
        report_problem("memory request after every row was already issued");
      end else begin
        if (wb_cycle[r] < 0 || wb_cycle[r] >= cycle) begin
          report_problem("memory request before the row's writeback was taken");
        end
        if (mem_req_tag !== t_tag[r]) show_mismatch("mem_req_tag", t_tag[r], mem_req_tag);
        if (mem_req_addr !== t_addr[r]) show_mismatch("mem_req_addr", t_addr[r], mem_req_addr);
        if (mem_req_value !== t_value[r]) begin
          show_mismatch("mem_req_value", t_value[r], mem_req_value);
        end
        if (mem_req_read !== t_read[r]) show_mismatch("mem_req_read", t_read[r], mem_req_read);
        if (!t_read[r] && rob_head_1 !== {3'b000, t_tag[r]} &&
            rob_head_2 !== {3'b000, t_tag[r]}) begin
          report_problem("store issued while the ROB head was not ready for it");
        end
        next_issue++;
      end
      requests++;
      outstanding++;
      if (outstanding > max_out) max_out = outstanding;
      if (outstanding > MEM_CREDITS) report_problem("more requests in flight than memory credits");
      ret_due.push_back(cycle + 1 + draw_bits(3));
    end
    if (next_issue == HOLD_ROW && hold_until == 0) hold_until = cycle + HOLD_CYCLES;
  endtask

  initial begin
    reset = 1'b1;
    disp_valid_1 = 1'b0;
    disp_valid_2 = 1'b0;
    disp_read_1 = 1'b0;
    disp_read_2 = 1'b0;
    disp_tag_1 = '0;
    disp_tag_2 = '0;
    ex_valid_1 = 1'b0;
    ex_valid_2 = 1'b0;
    ex_tag_1 = '0;
    ex_tag_2 = '0;
    ex_addr_1 = '0;
    ex_addr_2 = '0;
    ex_value_1 = '0;
    ex_value_2 = '0;
    rob_head_1 = {3'b111, TAG_W'(0)};
    rob_head_2 = {3'b111, TAG_W'(0)};
    mem_credit_return = 1'b0;
    disp_credits = LSQ_ENTRIES;
    min_credits = LSQ_ENTRIES;
    rob_row = -1;
    load_table();
    for (int i = 0; i < ROWS; i++) wb_cycle[i] = -1;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    while (next_issue < ROWS || ret_due.size() > 0) begin
      @(posedge clock);
      drive_cycle();
      @(negedge clock);
      observe_cycle();
    end
    if (requests != ROWS) report_problem("request count differs from the table length");
    if (credit_pulses != requests) report_problem("dispatch credit pulses differ from requests");
    if (disp_credits != LSQ_ENTRIES) report_problem("dispatch credits were not all returned");
    if (min_credits != 0) report_problem("the queue never filled up");
    if (max_out != MEM_CREDITS) report_problem("memory credits were never used up");
    $display("Summary: %0d value errors, %0d protocol errors, %0d requests",
             value_errors, protocol_errors, requests);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Bound scales with the table length
  initial begin
    repeat (ROWS * 40 + 200) @(posedge clock);
    $display("[ERROR] t=%0t watchdog expired with %0d of %0d requests seen",
             $time, next_issue, ROWS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- design/lsq_top.sv
// Load/store queue top with the queue and the memory credit counter
module lsq_top (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           disp_valid_1,
  input  logic [lsq_pkg::TAG_W-1:0]      disp_tag_1,
  input  logic                           disp_read_1,
  input  logic                           disp_valid_2,
  input  logic [lsq_pkg::TAG_W-1:0]      disp_tag_2,
  input  logic                           disp_read_2,
  input  logic                           ex_valid_1,
  input  logic [lsq_pkg::TAG_W-1:0]      ex_tag_1,
  input  logic [lsq_pkg::DATA_W-1:0]     ex_addr_1,
  input  logic [lsq_pkg::DATA_W-1:0]     ex_value_1,
  input  logic                           ex_valid_2,
  input  logic [lsq_pkg::TAG_W-1:0]      ex_tag_2,
  input  logic [lsq_pkg::DATA_W-1:0]     ex_addr_2,
  input  logic [lsq_pkg::DATA_W-1:0]     ex_value_2,
  input  logic [lsq_pkg::ROB_HEAD_W-1:0] rob_head_1,
  input  logic [lsq_pkg::ROB_HEAD_W-1:0] rob_head_2,
  input  logic                           mem_credit_return,
  output logic                           mem_req_valid,
  output logic [lsq_pkg::TAG_W-1:0]      mem_req_tag,
  output logic [lsq_pkg::DATA_W-1:0]     mem_req_addr,
  output logic [lsq_pkg::DATA_W-1:0]     mem_req_value,
  output logic                           mem_req_read,
  output logic                           disp_credit_return
);

  logic mem_credit_ok;

  lsq_queue u_queue (
    .clock              (clock),
    .reset              (reset),
    .disp_valid_1       (disp_valid_1),
    .disp_tag_1         (disp_tag_1),
    .disp_read_1        (disp_read_1),
    .disp_valid_2       (disp_valid_2),
    .disp_tag_2         (disp_tag_2),
    .disp_read_2        (disp_read_2),
    .ex_valid_1         (ex_valid_1),
    .ex_tag_1           (ex_tag_1),
    .ex_addr_1          (ex_addr_1),
    .ex_value_1         (ex_value_1),
    .ex_valid_2         (ex_valid_2),
    .ex_tag_2           (ex_tag_2),
    .ex_addr_2          (ex_addr_2),
    .ex_value_2         (ex_value_2),
    .rob_head_1         (rob_head_1),
    .rob_head_2         (rob_head_2),
    .mem_credit_ok      (mem_credit_ok),
    .mem_req_valid      (mem_req_valid),
    .mem_req_tag        (mem_req_tag),
    .mem_req_addr       (mem_req_addr),
    .mem_req_value      (mem_req_value),
    .mem_req_read       (mem_req_read),
    .disp_credit_return (disp_credit_return)
  );

  // Every issued request spends one memory credit
  lsq_mem_credit u_mem_credit (
    .clock         (clock),
    .reset         (reset),
    .spend         (mem_req_valid),
    .credit_return (mem_credit_return),
    .credit_ok     (mem_credit_ok)
  );

endmodule

//--- design/lsq_queue.sv
// Load/store queue pointers, allocation decode, slot array and in-order head issue
module lsq_queue (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           disp_valid_1,
  input  logic [lsq_pkg::TAG_W-1:0]      disp_tag_1,
  input  logic                           disp_read_1,
  input  logic                           disp_valid_2,
  input  logic [lsq_pkg::TAG_W-1:0]      disp_tag_2,
  input  logic                           disp_read_2,
  input  logic                           ex_valid_1,
  input  logic [lsq_pkg::TAG_W-1:0]      ex_tag_1,
  input  logic [lsq_pkg::DATA_W-1:0]     ex_addr_1,
  input  logic [lsq_pkg::DATA_W-1:0]     ex_value_1,
  input  logic                           ex_valid_2,
  input  logic [lsq_pkg::TAG_W-1:0]      ex_tag_2,
  input  logic [lsq_pkg::DATA_W-1:0]     ex_addr_2,
  input  logic [lsq_pkg::DATA_W-1:0]     ex_value_2,
  input  logic [lsq_pkg::ROB_HEAD_W-1:0] rob_head_1,
  input  logic [lsq_pkg::ROB_HEAD_W-1:0] rob_head_2,
  input  logic                           mem_credit_ok,
  output logic                           mem_req_valid,
  output logic [lsq_pkg::TAG_W-1:0]      mem_req_tag,
  output logic [lsq_pkg::DATA_W-1:0]     mem_req_addr,
  output logic [lsq_pkg::DATA_W-1:0]     mem_req_value,
  output logic                           mem_req_read,
  output logic                           disp_credit_return
);
  import lsq_pkg::*;

  logic [PTR_W-1:0]       head;
  logic [PTR_W-1:0]       tail;
  logic [PTR_W-1:0]       tail_plus_1;
  logic [PTR_W:0]         count;
  logic [1:0]             disp_num;

  logic [LSQ_ENTRIES-1:0] alloc_1;
  logic [LSQ_ENTRIES-1:0] alloc_2;
  logic [LSQ_ENTRIES-1:0] slot_clear;
  logic [LSQ_ENTRIES-1:0] slot_valid;
  logic [LSQ_ENTRIES-1:0] slot_complete;
  logic [LSQ_ENTRIES-1:0] slot_read;
  logic [TAG_W-1:0]       slot_tag   [LSQ_ENTRIES];
  logic [DATA_W-1:0]      slot_addr  [LSQ_ENTRIES];
  logic [DATA_W-1:0]      slot_value [LSQ_ENTRIES];

  logic                   head_match_1;
  logic                   head_match_2;
  logic                   head_ready;

  //////////////////////////////////////////////////////////////
  // Allocation decode
  //////////////////////////////////////////////////////////////

  assign tail_plus_1 = tail + 1'b1;
  assign disp_num    = {1'b0, disp_valid_1} + {1'b0, disp_valid_2};

  // Port 1 takes tail, port 2 the next slot, or tail when alone
  for (genvar i = 0; i < LSQ_ENTRIES; i++) begin : g_slot
    assign alloc_1[i] = disp_valid_1 & (tail == PTR_W'(i));
    assign alloc_2[i] = disp_valid_2 &
                        (disp_valid_1 ? (tail_plus_1 == PTR_W'(i)) : (tail == PTR_W'(i)));
    assign slot_clear[i] = mem_req_valid & (head == PTR_W'(i));

    lsq_entry u_entry (
      .clock       (clock),
      .reset       (reset),
      .clear       (slot_clear[i]),
      .alloc_1     (alloc_1[i]),
      .alloc_2     (alloc_2[i]),
      .disp_tag_1  (disp_tag_1),
      .disp_tag_2  (disp_tag_2),
      .disp_read_1 (disp_read_1),
      .disp_read_2 (disp_read_2),
      .ex_valid_1  (ex_valid_1),
      .ex_valid_2  (ex_valid_2),
      .ex_tag_1    (ex_tag_1),
      .ex_tag_2    (ex_tag_2),
      .ex_addr_1   (ex_addr_1),
      .ex_addr_2   (ex_addr_2),
      .ex_value_1  (ex_value_1),
      .ex_value_2  (ex_value_2),
      .valid       (slot_valid[i]),
      .complete    (slot_complete[i]),
      .tag         (slot_tag[i]),
      .addr        (slot_addr[i]),
      .value       (slot_value[i]),
      .read        (slot_read[i])
    );
  end

  //////////////////////////////////////////////////////////////
  // Head select and issue
  //////////////////////////////////////////////////////////////

  assign mem_req_tag   = slot_tag[head];
  assign mem_req_addr  = slot_addr[head];
  assign mem_req_value = slot_value[head];
  assign mem_req_read  = slot_read[head];

  // Head word counts only with all status flags clear
  assign head_match_1 = (rob_head_1[TAG_W-1:0] == mem_req_tag) &
                        (rob_head_1[ROB_HEAD_W-1:TAG_W] == '0);
  assign head_match_2 = (rob_head_2[TAG_W-1:0] == mem_req_tag) &
                        (rob_head_2[ROB_HEAD_W-1:TAG_W] == '0);

  // Stores wait for commit, loads go as soon as complete
  assign head_ready = slot_valid[head] & slot_complete[head] &
                      (mem_req_read | head_match_1 | head_match_2);

  assign mem_req_valid      = head_ready & mem_credit_ok;
  assign disp_credit_return = mem_req_valid;

  //////////////////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (mem_req_valid) begin
        head <= head + 1'b1;
      end
      tail  <= tail + PTR_W'(disp_num);
      count <= count + (PTR_W+1)'(disp_num) - (PTR_W+1)'(mem_req_valid);
    end
  end

  // Dispatcher credits keep allocation within the free slots
  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    (count + disp_num) <= LSQ_ENTRIES);

endmodule

//--- design/lsq_mem_credit.sv
// Memory-side credit counter that gates request issue
module lsq_mem_credit (
  input  logic clock,
  input  logic reset,
  input  logic spend,
  input  logic credit_return,
  output logic credit_ok
);
  import lsq_pkg::*;

  logic [MEM_CREDIT_W-1:0] count;

  // Spend and return in one cycle cancel out
  always_ff @(posedge clock) begin
    if (reset) begin
      count <= MEM_CREDIT_W'(MEM_CREDITS);
    end else begin
      case ({spend, credit_return})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign credit_ok = (count != '0);

  //////////////////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////////////////

  // Queue must see the gate before it issues
  a_spend_with_credit: assert property (@(posedge clock) disable iff (reset)
    spend |-> credit_ok);

  // Memory never hands back more than it was given
  a_pool_bound: assert property (@(posedge clock) disable iff (reset)
    count <= MEM_CREDIT_W'(MEM_CREDITS));

endmodule

//--- design/lsq_entry.sv
// Load/store queue slot with tag, kind, address, value and valid/complete state
module lsq_entry (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       clear,
  input  logic                       alloc_1,
  input  logic                       alloc_2,
  input  logic [lsq_pkg::TAG_W-1:0]  disp_tag_1,
  input  logic [lsq_pkg::TAG_W-1:0]  disp_tag_2,
  input  logic                       disp_read_1,
  input  logic                       disp_read_2,
  input  logic                       ex_valid_1,
  input  logic                       ex_valid_2,
  input  logic [lsq_pkg::TAG_W-1:0]  ex_tag_1,
  input  logic [lsq_pkg::TAG_W-1:0]  ex_tag_2,
  input  logic [lsq_pkg::DATA_W-1:0] ex_addr_1,
  input  logic [lsq_pkg::DATA_W-1:0] ex_addr_2,
  input  logic [lsq_pkg::DATA_W-1:0] ex_value_1,
  input  logic [lsq_pkg::DATA_W-1:0] ex_value_2,
  output logic                       valid,
  output logic                       complete,
  output logic [lsq_pkg::TAG_W-1:0]  tag,
  output logic [lsq_pkg::DATA_W-1:0] addr,
  output logic [lsq_pkg::DATA_W-1:0] value,
  output logic                       read
);
  import lsq_pkg::*;

  logic             alloc;
  logic [TAG_W-1:0] tag_next;
  logic             hit_1;
  logic             hit_2;

  assign alloc = alloc_1 | alloc_2;

  // Tag held after this edge, so a writeback can land on a fresh slot
  assign tag_next = alloc_1 ? disp_tag_1 : (alloc_2 ? disp_tag_2 : tag);

  assign hit_1 = ex_valid_1 & (valid | alloc) & (ex_tag_1 == tag_next);
  assign hit_2 = ex_valid_2 & (valid | alloc) & (ex_tag_2 == tag_next);

  // Status bits
  always_ff @(posedge clock) begin
    if (reset) begin
      valid    <= 1'b0;
      complete <= 1'b0;
    end else if (alloc) begin
      valid    <= 1'b1;
      complete <= hit_1 | hit_2;
    end else if (clear) begin
      valid    <= 1'b0;
      complete <= 1'b0;
    end else begin
      complete <= complete | hit_1 | hit_2;
    end
  end

  // Payload, port 1 wins on a shared tag
  always_ff @(posedge clock) begin
    if (alloc) begin
      tag  <= tag_next;
      read <= alloc_1 ? disp_read_1 : disp_read_2;
    end
    if (hit_1) begin
      addr  <= ex_addr_1;
      value <= ex_value_1;
    end else if (hit_2) begin
      addr  <= ex_addr_2;
      value <= ex_value_2;
    end
  end

  // Queue decode hands each slot to at most one dispatch port
  a_single_alloc: assert property (@(posedge clock) disable iff (reset)
    !(alloc_1 && alloc_2));

endmodule

//--- design/lsq_pkg.sv
// Shared widths, queue depth and memory credit pool for the load/store queue
package lsq_pkg;

  //////////////////////////////////////////////////////////////
  // ROB interface
  //////////////////////////////////////////////////////////////

  // ROB of 32 entries
  localparam int TAG_W = 5;

  // Head word: tag in the low bits, three status flags on top
  localparam int ROB_HEAD_W = 8;

  //////////////////////////////////////////////////////////////
  // Memory payload
  //////////////////////////////////////////////////////////////

  // Address and store data
  localparam int DATA_W = 64;

  //////////////////////////////////////////////////////////////
  // Queue sizing
  //////////////////////////////////////////////////////////////

  localparam int LSQ_ENTRIES = 16;
  localparam int PTR_W = 4;

  // Requests the memory side can hold at once
  localparam int MEM_CREDITS = 4;
  localparam int MEM_CREDIT_W = 3;

endpackage
